// ==== all.f ====
ex_pkg.sv
ex_operand_if.sv
alu_unit.sv
hilo_unit.sv
ex_result_reg.sv
ex_stage.sv
ex_stage_properties.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_ex_stage -f all.f -o tb_ex_stage
./obj_dir/tb_ex_stage | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int wait_limit = 8; // edges before a wait gives up

    // field order matches the input concatenation in issue()
    typedef struct packed {
        logic [alusel_width-1:0]   sel;
        logic [aluop_width-1:0]    op;
        logic [reg_width-1:0]      r1;
        logic [reg_width-1:0]      r2;
        logic                      wr;
        logic [reg_addr_width-1:0] wa;
        logic [reg_width-1:0]      hi;
        logic [reg_width-1:0]      lo;
        logic [reg_width-1:0]      mem_hi;
        logic [reg_width-1:0]      mem_lo;
        logic [reg_width-1:0]      wb_hi;
        logic [reg_width-1:0]      wb_lo;
        logic                      mem_w;
        logic                      wb_w;
    } stim_t;

    typedef struct packed {
        logic                      wreg;
        logic [reg_addr_width-1:0] waddr;
        logic [reg_width-1:0]      wdata;
        logic                      whilo;
        logic [reg_width-1:0]      hi;
        logic [reg_width-1:0]      lo;
    } exp_t;

    typedef struct {
        string name;
        exp_t  exp;
        int    left; // negedges until the result is due
        logic  acc;
    } item_t;

    logic                      clk_i;
    logic                      arst_n_i;
    logic [alusel_width-1:0]   alusel_i;
    logic [aluop_width-1:0]    aluop_i;
    logic [reg_width-1:0]      reg1_i, reg2_i;
    logic                      wreg_i;
    logic [reg_addr_width-1:0] waddr_i;
    logic [reg_width-1:0]      hi_i, lo_i, mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i;
    logic                      mem_whilo_i, wb_whilo_i;
    logic                      wreg_o, whilo_o, stall_o;
    logic [reg_addr_width-1:0] waddr_o;
    logic [reg_width-1:0]      wdata_o, hi_o, lo_o;

    logic [31:0] lfsr = 32'h230c874c;
    item_t       pending[$];
    item_t       cmp_item;
    int          checks = 0;
    int          errors = 0;
    int          test_base;
    string       test_name;
    logic        aborted = 1'b0;

    ex_stage i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] next_rand(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic stim_t make_stim();
        stim_t s;
        s        = '0;
        s.r1     = next_rand(32);
        s.r2     = next_rand(32);
        s.hi     = next_rand(32);
        s.lo     = next_rand(32);
        s.mem_hi = next_rand(32);
        s.mem_lo = next_rand(32);
        s.wb_hi  = next_rand(32);
        s.wb_lo  = next_rand(32);
        s.wa     = 5'(next_rand(5));
        return s;
    endfunction

    function automatic int count_lead(input logic [31:0] w, input logic b);
        int n;
        n = 0;
        while (n < 32 && w[31-n] == b) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic is_acc_op(input logic [aluop_width-1:0] op);
        return op inside {exe_madd_op, exe_maddu_op, exe_msub_op, exe_msubu_op};
    endfunction

    // expected stage outputs for one operation
    function automatic exp_t ref_model(input stim_t s);
        exp_t        e;
        hilo_u       fwd;
        hilo_u       prod;
        logic [32:0] wide;
        logic [31:0] res;
        logic        ovf;
        e   = '0;
        res = '0;
        ovf = 1'b0;
        if (s.mem_w) fwd.prod = {s.mem_hi, s.mem_lo};
        else if (s.wb_w) fwd.prod = {s.wb_hi, s.wb_lo};
        else fwd.prod = {s.hi, s.lo};
        if (s.op inside {exe_mult_op, exe_mul_op, exe_madd_op, exe_msub_op}) begin
            prod.prod = $signed({{32{s.r1[31]}}, s.r1}) * $signed({{32{s.r2[31]}}, s.r2});
        end else begin
            prod.prod = {32'h0, s.r1} * {32'h0, s.r2};
        end
        case (s.op)
            exe_and_op:  res = s.r1 & s.r2;
            exe_or_op:   res = s.r1 | s.r2;
            exe_xor_op:  res = s.r1 ^ s.r2;
            exe_nor_op:  res = ~(s.r1 | s.r2);
            exe_lui_op:  res = s.r2;
            exe_sll_op:  res = s.r2 << s.r1[4:0];
            exe_srl_op:  res = s.r2 >> s.r1[4:0];
            exe_sra_op:  res = 32'($signed(s.r2) >>> s.r1[4:0]);
            exe_mfhi_op: res = fwd.half.hi;
            exe_mflo_op: res = fwd.half.lo;
            exe_movz_op, exe_movn_op: res = s.r1;
            exe_add_op, exe_addu_op, exe_sub_op, exe_subu_op: begin
                if (s.op inside {exe_add_op, exe_addu_op}) begin
                    wide = {s.r1[31], s.r1} + {s.r2[31], s.r2};
                end else begin
                    wide = {s.r1[31], s.r1} - {s.r2[31], s.r2};
                end
                res = wide[31:0];
                ovf = wide[32] ^ wide[31]; // 33-bit sign disagrees
            end
            exe_slt_op:  res = {31'h0, $signed(s.r1) < $signed(s.r2)};
            exe_sltu_op: res = {31'h0, s.r1 < s.r2};
            exe_clz_op:  res = 32'(count_lead(s.r1, 1'b0));
            exe_clo_op:  res = 32'(count_lead(s.r1, 1'b1));
            exe_mul_op:  res = prod.half.lo;
            exe_mthi_op: {e.whilo, e.hi, e.lo} = {1'b1, s.r1, fwd.half.lo};
            exe_mtlo_op: {e.whilo, e.hi, e.lo} = {1'b1, fwd.half.hi, s.r1};
            exe_mult_op, exe_multu_op: {e.whilo, e.hi, e.lo} = {1'b1, prod.prod};
            exe_madd_op, exe_maddu_op: {e.whilo, e.hi, e.lo} = {1'b1, fwd.prod + prod.prod};
            exe_msub_op, exe_msubu_op: {e.whilo, e.hi, e.lo} = {1'b1, fwd.prod - prod.prod};
            default:     res = '0;
        endcase
        e.wdata = (s.sel == exe_res_nop) ? '0 : res;
        e.wreg  = s.wr && !(ovf && (s.op inside {exe_add_op, exe_sub_op}));
        e.waddr = s.wa;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    task automatic end_test();
        $display("test %-14s %s, %0d mismatches", test_name,
                 (errors == test_base) ? "passed" : "FAILED", errors - test_base);
    endtask

    // present one operation, hold it through the stall, then go idle
    task automatic issue(input string name, input stim_t s);
        stim_t idle;
        item_t it;
        int    n;
        if (aborted) return;
        idle     = s;
        idle.op  = exe_nop_op;
        idle.sel = exe_res_nop;
        idle.wr  = 1'b0;
        @(posedge clk_i);
        {alusel_i, aluop_i, reg1_i, reg2_i, wreg_i, waddr_i, hi_i, lo_i,
         mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i, mem_whilo_i, wb_whilo_i} <= s;
        it.name = name;
        it.exp  = ref_model(s);
        it.acc  = is_acc_op(s.op);
        it.left = it.acc ? 2 : 1;
        pending.push_back(it);
        n = 0;
        @(negedge clk_i);
        while (stall_o && n < wait_limit) begin
            @(negedge clk_i);
            n++;
        end
        if (stall_o) begin
            $display("%s: stall_o did not drop within %0d cycles", name, wait_limit);
            errors++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk_i);
        {alusel_i, aluop_i, reg1_i, reg2_i, wreg_i, waddr_i, hi_i, lo_i,
         mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i, mem_whilo_i, wb_whilo_i} <= idle;
        n = 0;
        while (pending.size() > 0 && n < wait_limit) begin
            @(posedge clk_i);
            n++;
        end
        if (pending.size() > 0) begin
            $display("%s: result was never compared", name);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_op(input string name, input logic [aluop_width-1:0] op,
                          input logic [alusel_width-1:0] sel, input logic wr, input stim_t base);
        stim_t s;
        s     = base;
        s.op  = op;
        s.sel = sel;
        s.wr  = wr;
        issue(name, s);
    endtask

    // compare process, outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (pending.size() > 0) begin
            cmp_item = pending[0];
            if (cmp_item.left == 2) begin
                check({cmp_item.name, " stall"}, 32'd1, 32'(stall_o));
            end else if (cmp_item.left == 1) begin
                check({cmp_item.name, " stall"}, 32'd0, 32'(stall_o));
                if (cmp_item.acc) begin
                    check({cmp_item.name, " bubble wreg"}, 32'd0, 32'(wreg_o));
                    check({cmp_item.name, " bubble whilo"}, 32'd0, 32'(whilo_o));
                end
            end else begin
                check({cmp_item.name, " wreg"}, 32'(cmp_item.exp.wreg), 32'(wreg_o));
                check({cmp_item.name, " waddr"}, 32'(cmp_item.exp.waddr), 32'(waddr_o));
                check({cmp_item.name, " wdata"}, cmp_item.exp.wdata, wdata_o);
                check({cmp_item.name, " whilo"}, 32'(cmp_item.exp.whilo), 32'(whilo_o));
                check({cmp_item.name, " hi"}, cmp_item.exp.hi, hi_o);
                check({cmp_item.name, " lo"}, cmp_item.exp.lo, lo_o);
            end
            if (cmp_item.left == 0) begin
                void'(pending.pop_front());
            end else begin
                cmp_item.left--;
                pending[0] = cmp_item;
            end
        end
    end

    initial begin
        stim_t s;
        arst_n_i = 1'b0;
        s        = make_stim(); // a writing mult held while in reset
        s.op     = exe_mult_op;
        s.sel    = exe_res_mul;
        s.wr     = 1'b1;
        s.wa[0]  = 1'b1;
        {alusel_i, aluop_i, reg1_i, reg2_i, wreg_i, waddr_i, hi_i, lo_i,
         mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i, mem_whilo_i, wb_whilo_i} = s;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        {alusel_i, aluop_i, reg1_i, reg2_i, wreg_i, waddr_i, hi_i, lo_i,
         mem_hi_i, mem_lo_i, wb_hi_i, wb_lo_i, mem_whilo_i, wb_whilo_i} <= '0;

        begin_test("reset");
        @(negedge clk_i);
        check("reset wreg", 32'd0, 32'(wreg_o));
        check("reset whilo", 32'd0, 32'(whilo_o));
        check("reset stall", 32'd0, 32'(stall_o));
        check("reset waddr", 32'd0, 32'(waddr_o));
        check("reset wdata", 32'd0, wdata_o);
        check("reset hi", 32'd0, hi_o);
        check("reset lo", 32'd0, lo_o);
        end_test();

        begin_test("logic_shift");
        for (int i = 0; i < 3; i++) begin
            s = make_stim();
            run_op("and", exe_and_op, exe_res_logic, 1'b1, s);
            run_op("or", exe_or_op, exe_res_logic, 1'b1, s);
            run_op("xor", exe_xor_op, exe_res_logic, 1'b1, s);
            run_op("nor", exe_nor_op, exe_res_logic, 1'b1, s);
            run_op("sll", exe_sll_op, exe_res_shift, 1'b1, s);
            run_op("srl", exe_srl_op, exe_res_shift, 1'b1, s);
            s.r2[31] = 1'b1; // negative operand for sra
            run_op("sra", exe_sra_op, exe_res_shift, 1'b1, s);
            s.r2 = {s.r2[15:0], 16'h0};
            run_op("lui", exe_lui_op, exe_res_logic, 1'b1, s);
        end
        end_test();

        begin_test("arith");
        s = make_stim();
        {s.r1, s.r2} = {32'h7fff_fff0, 32'h0000_0100};
        run_op("add ovf", exe_add_op, exe_res_arith, 1'b1, s);
        run_op("addu wrap", exe_addu_op, exe_res_arith, 1'b1, s);
        {s.r1, s.r2} = {32'h8000_0000, 32'h0000_0001};
        run_op("sub ovf", exe_sub_op, exe_res_arith, 1'b1, s);
        run_op("subu wrap", exe_subu_op, exe_res_arith, 1'b1, s);
        {s.r1, s.r2} = {32'hffff_ffff, 32'h0000_0001}; // mixed signs
        run_op("slt mixed", exe_slt_op, exe_res_arith, 1'b1, s);
        run_op("sltu mixed", exe_sltu_op, exe_res_arith, 1'b1, s);
        run_op("clz ones", exe_clz_op, exe_res_arith, 1'b1, s);
        run_op("clo ones", exe_clo_op, exe_res_arith, 1'b1, s);
        s.r1 = '0;
        run_op("clz zero", exe_clz_op, exe_res_arith, 1'b1, s);
        run_op("clo zero", exe_clo_op, exe_res_arith, 1'b1, s);
        for (int i = 0; i < 3; i++) begin
            s = make_stim();
            run_op("add", exe_add_op, exe_res_arith, 1'b1, s);
            run_op("addu", exe_addu_op, exe_res_arith, 1'b1, s);
            run_op("sub", exe_sub_op, exe_res_arith, 1'b1, s);
            run_op("subu", exe_subu_op, exe_res_arith, 1'b1, s);
            run_op("slt", exe_slt_op, exe_res_arith, 1'b1, s);
            run_op("sltu", exe_sltu_op, exe_res_arith, 1'b1, s);
            s.r1 = s.r1 >> s.r2[4:0];
            run_op("clz", exe_clz_op, exe_res_arith, 1'b1, s);
            s.r1 = ~s.r1;
            run_op("clo", exe_clo_op, exe_res_arith, 1'b1, s);
        end
        end_test();

        begin_test("multiply");
        for (int i = 0; i < 4; i++) begin
            s        = make_stim();
            s.r1[31] = i[0]; // all sign pairs
            s.r2[31] = i[1];
            run_op("mult", exe_mult_op, exe_res_nop, 1'b0, s);
            run_op("multu", exe_multu_op, exe_res_nop, 1'b0, s);
            run_op("mul", exe_mul_op, exe_res_mul, 1'b1, s);
        end
        end_test();

        begin_test("hilo_forward");
        for (int f = 0; f < 4; f++) begin
            s       = make_stim();
            s.mem_w = f[0];
            s.wb_w  = f[1];
            run_op("mthi", exe_mthi_op, exe_res_nop, 1'b0, s);
            run_op("mtlo", exe_mtlo_op, exe_res_nop, 1'b0, s);
            run_op("mfhi", exe_mfhi_op, exe_res_move, 1'b1, s);
            run_op("mflo", exe_mflo_op, exe_res_move, 1'b1, s);
            s.r2 = '0;
            run_op("movz taken", exe_movz_op, exe_res_move, 1'b1, s);
            s.r2 = next_rand(32) | 32'h1;
            run_op("movn taken", exe_movn_op, exe_res_move, 1'b1, s);
            run_op("movz skipped", exe_movz_op, exe_res_move, 1'b0, s);
        end
        end_test();

        // wreg held high so the bubble has a write to drop
        begin_test("accumulate");
        for (int f = 0; f < 4; f++) begin
            s       = make_stim();
            s.mem_w = f[0];
            s.wb_w  = f[1];
            run_op("madd", exe_madd_op, exe_res_nop, 1'b1, s);
            run_op("maddu", exe_maddu_op, exe_res_nop, 1'b1, s);
            run_op("msub", exe_msub_op, exe_res_nop, 1'b1, s);
            run_op("msubu", exe_msubu_op, exe_res_nop, 1'b1, s);
        end
        end_test();

        $display("checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== ex_stage_properties.sv ====
module ex_stage_properties (
    input logic                           clk_i,
    input logic                           arst_n_i,
    input logic [ex_pkg::aluop_width-1:0] aluop_i,
    input logic                           stall_o,
    input logic                           wreg_o,
    input logic                           whilo_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a held accumulate stalls once, not twice
    stall_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ($past(stall_o) && (aluop_i == $past(aluop_i))) |-> !stall_o)
        else $error("stall_o high on two cycles for one held operation");

    // the stall edge registers a bubble
    bubble_after_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(stall_o) |-> !whilo_o)
        else $error("whilo_o high in the cycle after stall_o");

    quiet_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!wreg_o && !whilo_o))
        else $error("write enables high while reset is asserted");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .aluop_i  (aluop_i),
    .stall_o  (stall_o),
    .wreg_o   (wreg_o),
    .whilo_o  (whilo_o)
);

// ==== ex_stage.sv ====
module ex_stage (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [ex_pkg::alusel_width-1:0]   alusel_i,
    input  logic [ex_pkg::aluop_width-1:0]    aluop_i,
    input  logic [ex_pkg::reg_width-1:0]      reg1_i,
    input  logic [ex_pkg::reg_width-1:0]      reg2_i,
    input  logic                              wreg_i,
    input  logic [ex_pkg::reg_addr_width-1:0] waddr_i,
    input  logic [ex_pkg::reg_width-1:0]      hi_i,
    input  logic [ex_pkg::reg_width-1:0]      lo_i,
    input  logic [ex_pkg::reg_width-1:0]      mem_hi_i,
    input  logic [ex_pkg::reg_width-1:0]      mem_lo_i,
    input  logic [ex_pkg::reg_width-1:0]      wb_hi_i,
    input  logic [ex_pkg::reg_width-1:0]      wb_lo_i,
    input  logic                              mem_whilo_i,
    input  logic                              wb_whilo_i,
    output logic                              wreg_o,
    output logic [ex_pkg::reg_addr_width-1:0] waddr_o,
    output logic [ex_pkg::reg_width-1:0]      wdata_o,
    output logic [ex_pkg::reg_width-1:0]      hi_o,
    output logic [ex_pkg::reg_width-1:0]      lo_o,
    output logic                              whilo_o,
    output logic                              stall_o
);
    import ex_pkg::*;

    logic [reg_width-1:0] alu_wdata;
    logic                 ov_sum;
    logic                 hilo_whilo; // before the output register
    logic [reg_width-1:0] hi_wdata;
    logic [reg_width-1:0] lo_wdata;
    logic [reg_width-1:0] mul_lo;

    ex_operand_if op_if ();

    assign op_if.aluop = aluop_i;
    assign op_if.reg1  = reg1_i;
    assign op_if.reg2  = reg2_i;

    alu_unit u_alu (
        .op_if       (op_if),
        .alu_wdata_o (alu_wdata),
        .ov_sum_o    (ov_sum)
    );

    hilo_unit u_hilo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .op_if       (op_if),
        .hi_i        (hi_i),
        .lo_i        (lo_i),
        .mem_hi_i    (mem_hi_i),
        .mem_lo_i    (mem_lo_i),
        .wb_hi_i     (wb_hi_i),
        .wb_lo_i     (wb_lo_i),
        .mem_whilo_i (mem_whilo_i),
        .wb_whilo_i  (wb_whilo_i),
        .stall_o     (stall_o),
        .whilo_o     (hilo_whilo),
        .hi_wdata_o  (hi_wdata),
        .lo_wdata_o  (lo_wdata),
        .mul_lo_o    (mul_lo)
    );

    ex_result_reg u_result (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .alusel_i    (alusel_i),
        .aluop_i     (aluop_i),
        .wreg_i      (wreg_i),
        .waddr_i     (waddr_i),
        .alu_wdata_i (alu_wdata),
        .ov_sum_i    (ov_sum),
        .mul_lo_i    (mul_lo),
        .stall_i     (stall_o),
        .whilo_i     (hilo_whilo),
        .hi_wdata_i  (hi_wdata),
        .lo_wdata_i  (lo_wdata),
        .wreg_o      (wreg_o),
        .waddr_o     (waddr_o),
        .wdata_o     (wdata_o),
        .whilo_o     (whilo_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

endmodule

// ==== ex_result_reg.sv ====
module ex_result_reg (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [ex_pkg::alusel_width-1:0]   alusel_i,
    input  logic [ex_pkg::aluop_width-1:0]    aluop_i,
    input  logic                              wreg_i,
    input  logic [ex_pkg::reg_addr_width-1:0] waddr_i,
    input  logic [ex_pkg::reg_width-1:0]      alu_wdata_i,
    input  logic                              ov_sum_i,
    input  logic [ex_pkg::reg_width-1:0]      mul_lo_i,
    input  logic                              stall_i,
    input  logic                              whilo_i,
    input  logic [ex_pkg::reg_width-1:0]      hi_wdata_i,
    input  logic [ex_pkg::reg_width-1:0]      lo_wdata_i,
    output logic                              wreg_o,
    output logic [ex_pkg::reg_addr_width-1:0] waddr_o,
    output logic [ex_pkg::reg_width-1:0]      wdata_o,
    output logic                              whilo_o,
    output logic [ex_pkg::reg_width-1:0]      hi_o,
    output logic [ex_pkg::reg_width-1:0]      lo_o
);
    import ex_pkg::*;

    logic [reg_width-1:0] wdata_d;
    logic                 wreg_d;
    hilo_u                hilo_q;

    always_comb begin
        case (alusel_i)
            exe_res_logic, exe_res_shift,
            exe_res_move, exe_res_arith: wdata_d = alu_wdata_i;
            exe_res_mul:                 wdata_d = mul_lo_i; // mul keeps the low word
            default:                     wdata_d = '0;
        endcase
    end

    // trapping add/sub must not reach the register file
    assign wreg_d = wreg_i &&
                    !(((aluop_i == exe_add_op) || (aluop_i == exe_sub_op)) && ov_sum_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wreg_o  <= 1'b0;
            waddr_o <= '0;
            wdata_o <= '0;
            whilo_o <= 1'b0;
            hilo_q  <= '0;
        end else if (stall_i) begin
            wreg_o  <= 1'b0; // bubble
            waddr_o <= '0;
            wdata_o <= '0;
            whilo_o <= 1'b0;
            hilo_q  <= '0;
        end else begin
            wreg_o         <= wreg_d;
            waddr_o        <= waddr_i;
            wdata_o        <= wdata_d;
            whilo_o        <= whilo_i;
            hilo_q.half.hi <= hi_wdata_i;
            hilo_q.half.lo <= lo_wdata_i;
        end
    end

    assign hi_o = hilo_q.half.hi;
    assign lo_o = hilo_q.half.lo;

endmodule

// ==== hilo_unit.sv ====
module hilo_unit (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    ex_operand_if.hilo                   op_if,
    input  logic [ex_pkg::reg_width-1:0] hi_i,
    input  logic [ex_pkg::reg_width-1:0] lo_i,
    input  logic [ex_pkg::reg_width-1:0] mem_hi_i,
    input  logic [ex_pkg::reg_width-1:0] mem_lo_i,
    input  logic [ex_pkg::reg_width-1:0] wb_hi_i,
    input  logic [ex_pkg::reg_width-1:0] wb_lo_i,
    input  logic                         mem_whilo_i,
    input  logic                         wb_whilo_i,
    output logic                         stall_o,
    output logic                         whilo_o,
    output logic [ex_pkg::reg_width-1:0] hi_wdata_o,
    output logic [ex_pkg::reg_width-1:0] lo_wdata_o,
    output logic [ex_pkg::reg_width-1:0] mul_lo_o
);
    import ex_pkg::*;

    localparam int dw = 2 * reg_width;

    hilo_u                fwd;         // HI/LO after forwarding
    hilo_u                prod;
    hilo_u                acc_q;       // product taken in the stall cycle
    hilo_u                acc_sum;
    logic [reg_width-1:0] op1_abs;
    logic [reg_width-1:0] op2_abs;
    logic [dw-1:0]        mag;
    logic                 is_signed;
    logic                 is_acc;
    logic                 is_msub;
    logic                 acc_phase_q; // second cycle of an accumulate

    // mem is newer than wb
    always_comb begin
        if (mem_whilo_i) begin
            fwd.half.hi = mem_hi_i;
            fwd.half.lo = mem_lo_i;
        end else if (wb_whilo_i) begin
            fwd.half.hi = wb_hi_i;
            fwd.half.lo = wb_lo_i;
        end else begin
            fwd.half.hi = hi_i;
            fwd.half.lo = lo_i;
        end
    end

    assign op_if.cur_hi = fwd.half.hi;
    assign op_if.cur_lo = fwd.half.lo;

    assign is_signed = (op_if.aluop == exe_mult_op) || (op_if.aluop == exe_mul_op) ||
                       (op_if.aluop == exe_madd_op) || (op_if.aluop == exe_msub_op);
    assign is_msub   = (op_if.aluop == exe_msub_op) || (op_if.aluop == exe_msubu_op);
    assign is_acc    = is_msub || (op_if.aluop == exe_madd_op) ||
                       (op_if.aluop == exe_maddu_op);

    // multiply magnitudes, fix the sign afterwards
    assign op1_abs  = (is_signed && op_if.reg1[reg_width-1]) ? -op_if.reg1 : op_if.reg1;
    assign op2_abs  = (is_signed && op_if.reg2[reg_width-1]) ? -op_if.reg2 : op_if.reg2;
    assign mag      = dw'(op1_abs) * dw'(op2_abs);
    assign prod.prod = (is_signed && (op_if.reg1[reg_width-1] ^ op_if.reg2[reg_width-1])) ?
                       -mag : mag;
    assign mul_lo_o  = prod.half.lo;

    // first cycle of an accumulate asks upstream to hold
    assign stall_o = is_acc && !acc_phase_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_phase_q <= 1'b0;
            acc_q       <= '0;
        end else begin
            acc_phase_q <= stall_o;
            if (stall_o) begin
                acc_q.prod <= is_msub ? -prod.prod : prod.prod; // msub adds the negation
            end
        end
    end

    assign acc_sum.prod = acc_q.prod + fwd.prod;

    always_comb begin
        whilo_o    = 1'b1;
        hi_wdata_o = '0;
        lo_wdata_o = '0;
        case (op_if.aluop)
            exe_mthi_op: begin
                hi_wdata_o = op_if.reg1;
                lo_wdata_o = fwd.half.lo; // lo unchanged
            end
            exe_mtlo_op: begin
                hi_wdata_o = fwd.half.hi;
                lo_wdata_o = op_if.reg1;
            end
            exe_mult_op, exe_multu_op: begin
                hi_wdata_o = prod.half.hi;
                lo_wdata_o = prod.half.lo;
            end
            exe_madd_op, exe_maddu_op, exe_msub_op, exe_msubu_op: begin
                hi_wdata_o = acc_sum.half.hi; // only taken in the second cycle
                lo_wdata_o = acc_sum.half.lo;
            end
            default: whilo_o = 1'b0;
        endcase
    end

endmodule

// ==== alu_unit.sv ====
module alu_unit (
    ex_operand_if.alu                    op_if,
    output logic [ex_pkg::reg_width-1:0] alu_wdata_o,
    output logic                         ov_sum_o
);
    import ex_pkg::*;

    localparam int sh_width  = $clog2(reg_width);
    localparam int cnt_width = sh_width + 1; // count can reach reg_width

    logic [reg_width-1:0] logic_res;
    logic [reg_width-1:0] shift_res;
    logic [reg_width-1:0] move_res;
    logic [reg_width-1:0] arith_res;
    logic [reg_width-1:0] reg2_mux;
    logic [reg_width-1:0] sum;
    logic                 is_sub;
    logic [sh_width-1:0]  sh_amt;

    // leading bits equal to val, counted from the msb
    function automatic logic [cnt_width-1:0] lead_count(
        input logic [reg_width-1:0] word,
        input logic                 val
    );
        logic [cnt_width-1:0] cnt;
        logic                 done;
        cnt  = '0;
        done = 1'b0;
        for (int i = reg_width - 1; i >= 0; i--) begin
            if (done || (word[i] != val)) begin
                done = 1'b1;
            end else begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    always_comb begin
        case (op_if.aluop)
            exe_and_op: logic_res = op_if.reg1 & op_if.reg2;
            exe_or_op:  logic_res = op_if.reg1 | op_if.reg2;
            exe_xor_op: logic_res = op_if.reg1 ^ op_if.reg2;
            exe_nor_op: logic_res = ~(op_if.reg1 | op_if.reg2);
            exe_lui_op: logic_res = op_if.reg2; // immediate comes in already shifted
            default:    logic_res = '0;
        endcase
    end

    assign sh_amt = op_if.reg1[sh_width-1:0];

    always_comb begin
        case (op_if.aluop)
            exe_sll_op: shift_res = op_if.reg2 << sh_amt;
            exe_srl_op: shift_res = op_if.reg2 >> sh_amt;
            exe_sra_op: shift_res = $signed(op_if.reg2) >>> sh_amt; // sign fill
            default:    shift_res = '0;
        endcase
    end

    // movz/movn condition is resolved by decode through wreg
    always_comb begin
        case (op_if.aluop)
            exe_mfhi_op:              move_res = op_if.cur_hi;
            exe_mflo_op:              move_res = op_if.cur_lo;
            exe_movz_op, exe_movn_op: move_res = op_if.reg1;
            default:                  move_res = '0;
        endcase
    end

    assign is_sub   = (op_if.aluop == exe_sub_op) || (op_if.aluop == exe_subu_op);
    assign reg2_mux = is_sub ? (~op_if.reg2 + 1'b1) : op_if.reg2;
    assign sum      = op_if.reg1 + reg2_mux;

    // add overflows on like signs, sub on unlike signs
    assign ov_sum_o = ((op_if.reg1[reg_width-1] ^ op_if.reg2[reg_width-1]) == is_sub) &&
                      (sum[reg_width-1] != op_if.reg1[reg_width-1]);

    always_comb begin
        case (op_if.aluop)
            exe_add_op, exe_addu_op, exe_sub_op, exe_subu_op: begin
                arith_res = sum;
            end
            exe_slt_op: begin
                arith_res = {{(reg_width-1){1'b0}},
                             $signed(op_if.reg1) < $signed(op_if.reg2)};
            end
            exe_sltu_op: begin
                arith_res = {{(reg_width-1){1'b0}}, op_if.reg1 < op_if.reg2};
            end
            exe_clz_op: arith_res = reg_width'(lead_count(op_if.reg1, 1'b0));
            exe_clo_op: arith_res = reg_width'(lead_count(op_if.reg1, 1'b1));
            default:    arith_res = '0;
        endcase
    end

    // op codes of the four groups are disjoint, the others stay zero
    assign alu_wdata_o = logic_res | shift_res | move_res | arith_res;

endmodule

// ==== ex_operand_if.sv ====
interface ex_operand_if;
    import ex_pkg::*;

    logic [aluop_width-1:0] aluop;
    logic [reg_width-1:0]   reg1;
    logic [reg_width-1:0]   reg2;
    logic [reg_width-1:0]   cur_hi; // HI after forwarding
    logic [reg_width-1:0]   cur_lo; // LO after forwarding

    // multiplier side resolves the forwarded HI/LO
    modport hilo (
        input  aluop,
        input  reg1,
        input  reg2,
        output cur_hi,
        output cur_lo
    );

    modport alu (
        input aluop,
        input reg1,
        input reg2,
        input cur_hi,
        input cur_lo
    );

endinterface

// ==== ex_pkg.sv ====
package ex_pkg;

    localparam int reg_width      = 32;
    localparam int reg_addr_width = 5;
    localparam int aluop_width    = 8;
    localparam int alusel_width   = 3;

    // operation codes
    localparam logic [aluop_width-1:0] exe_nop_op   = 8'b0000_0000;
    localparam logic [aluop_width-1:0] exe_and_op   = 8'b0010_0100;
    localparam logic [aluop_width-1:0] exe_or_op    = 8'b0010_0101;
    localparam logic [aluop_width-1:0] exe_xor_op   = 8'b0010_0110;
    localparam logic [aluop_width-1:0] exe_nor_op   = 8'b0010_0111;
    localparam logic [aluop_width-1:0] exe_lui_op   = 8'b0101_1100;
    localparam logic [aluop_width-1:0] exe_sll_op   = 8'b0111_1100;
    localparam logic [aluop_width-1:0] exe_srl_op   = 8'b0000_0010;
    localparam logic [aluop_width-1:0] exe_sra_op   = 8'b0000_0011;
    localparam logic [aluop_width-1:0] exe_mfhi_op  = 8'b0001_0000;
    localparam logic [aluop_width-1:0] exe_mthi_op  = 8'b0001_0001;
    localparam logic [aluop_width-1:0] exe_mflo_op  = 8'b0001_0010;
    localparam logic [aluop_width-1:0] exe_mtlo_op  = 8'b0001_0011;
    localparam logic [aluop_width-1:0] exe_movz_op  = 8'b0000_1010;
    localparam logic [aluop_width-1:0] exe_movn_op  = 8'b0000_1011;
    localparam logic [aluop_width-1:0] exe_add_op   = 8'b0010_0000;
    localparam logic [aluop_width-1:0] exe_addu_op  = 8'b0010_0001;
    localparam logic [aluop_width-1:0] exe_sub_op   = 8'b0010_0010;
    localparam logic [aluop_width-1:0] exe_subu_op  = 8'b0010_0011;
    localparam logic [aluop_width-1:0] exe_slt_op   = 8'b0010_1010;
    localparam logic [aluop_width-1:0] exe_sltu_op  = 8'b0010_1011;
    localparam logic [aluop_width-1:0] exe_clz_op   = 8'b1011_0000;
    localparam logic [aluop_width-1:0] exe_clo_op   = 8'b1011_0001;
    localparam logic [aluop_width-1:0] exe_mul_op   = 8'b1010_1001;
    localparam logic [aluop_width-1:0] exe_mult_op  = 8'b0001_1000;
    localparam logic [aluop_width-1:0] exe_multu_op = 8'b0001_1001;
    localparam logic [aluop_width-1:0] exe_madd_op  = 8'b1010_0110;
    localparam logic [aluop_width-1:0] exe_maddu_op = 8'b1010_1000;
    localparam logic [aluop_width-1:0] exe_msub_op  = 8'b1010_1010;
    localparam logic [aluop_width-1:0] exe_msubu_op = 8'b1010_1011;

    // result class, picks the source of the register write data
    localparam logic [alusel_width-1:0] exe_res_nop   = 3'b000;
    localparam logic [alusel_width-1:0] exe_res_logic = 3'b001;
    localparam logic [alusel_width-1:0] exe_res_shift = 3'b010;
    localparam logic [alusel_width-1:0] exe_res_move  = 3'b011;
    localparam logic [alusel_width-1:0] exe_res_arith = 3'b100;
    localparam logic [alusel_width-1:0] exe_res_mul   = 3'b101;

    typedef struct packed {
        logic [reg_width-1:0] hi;
        logic [reg_width-1:0] lo;
    } hilo_pair_t;

    // HI/LO pair, seen as one product or as two words
    typedef union packed {
        logic [2*reg_width-1:0] prod;
        hilo_pair_t             half;
    } hilo_u;

endpackage
